//--- flist.f
+incdir+common
+incdir+bench
common/predecPkg.sv
hdl/predecBoundary.sv
hdl/predecClassify.sv
hdl/predecSlotPick.sv
hdl/predecTop.sv
bench/predecTb.sv

//--- Bender.yml
package:
  name: predec

sources:
  - include_dirs:
      - common
    files:
      - common/predecPkg.sv
      - hdl/predecBoundary.sv
      - hdl/predecClassify.sv
      - hdl/predecSlotPick.sv
      - hdl/predecTop.sv
  - target: test
    include_dirs:
      - common
      - bench
    files:
      - bench/predecTb.sv

//--- bench/predecModel.svh
// ==============================
// predecoder reference model
// expected slots, classes and flags for one bundle
// ==============================
`ifndef PREDEC_MODEL_SVH
`define PREDEC_MODEL_SVH

typedef struct packed {
  predecPkg::window_t [`PREDEC_SLOTS-1:0]  instr;
  predecPkg::magic_t [`PREDEC_SLOTS-1:0]   magic;
  logic [`PREDEC_SLOTS-1:0][3:0]           off;
  predecPkg::cls_t [`PREDEC_SLOTS-1:0]     cls;
  logic [`PREDEC_SLOTS-1:0]                instrEn;
  predecPkg::window_t [`PREDEC_JSLOTS-1:0] jInstr;
  predecPkg::magic_t [`PREDEC_JSLOTS-1:0]  jMagic;
  logic [`PREDEC_JSLOTS-1:0][3:0]          jOff;
  predecPkg::cls_t [`PREDEC_JSLOTS-1:0]    jCls;
  logic [`PREDEC_JSLOTS-1:0]               jEn;
  logic                                    hasJumps;
  logic                                    error;
  logic                                    jerror;
} predResult_t;

function automatic predecPkg::cls_t classRef(input logic [7:0] op, input logic [2:0] sub,
                                             input logic isLong, input logic flag);
  predecPkg::cls_t c;
  c = '0;
  if (isLong) begin
    if (op <= 8'd31) c[op[2] ? `CLS_MUL : `CLS_ALU] = 1'b1;
    if (op >= 8'd40 && op <= 8'd45) c[`CLS_SHIFT] = 1'b1;
    if (op >= 8'd46 && op <= 8'd51) c[`CLS_ALU] = 1'b1;
    if (op >= 8'd64 && op <= 8'd95) c[op[0] ? `CLS_STORE : `CLS_LOAD] = 1'b1;
    if (op >= 8'd160 && op <= 8'd175) begin
      c[`CLS_JUMP] = 1'b1;
      c[`CLS_ALU]  = 1'b1;
    end
    if (op == predecPkg::opCondJumpLong || op == predecPkg::opJump) c[`CLS_JUMP] = 1'b1;
    if (op == predecPkg::opJumpMisc) begin
      c[`CLS_JUMP] = 1'b1;
      if (sub == predecPkg::jkIndir || sub == predecPkg::jkRet) c[`CLS_INDIR] = 1'b1;
      if (sub == predecPkg::jkCall || sub == predecPkg::jkCallFar) c[`CLS_STORE] = 1'b1;
    end
    if (op == predecPkg::opSys) c[`CLS_SYS] = 1'b1;
  end else begin
    if (op[5:4] == 2'b00) c[`CLS_ALU] = 1'b1;
    if (op[5:2] == 4'b1100) c[`CLS_JUMP] = 1'b1;
  end
  c[`CLS_FLAG] = flag;
  return c;
endfunction

function automatic predResult_t predecodeRef(input logic [255:0] bun, input logic [3:0] so,
                                             input logic [14:0] flags);
  predResult_t r;
  logic [14:0] ends;
  logic [319:0] text;  // zero text past parcel 14
  predecPkg::window_t w;
  predecPkg::magic_t mg;
  predecPkg::cls_t c;
  int lastEnd;
  int e;
  int nI;
  int nJ;
  r = '0;
  ends = bun[254:240];
  text = {80'b0, bun[239:0]};
  lastEnd = -1;
  nI = 0;
  nJ = 0;
  for (int k = 0; k < 15; k++) begin
    if (ends[k]) lastEnd = k;
  end
  r.error = (so == 4'd15);
  for (int k = 0; k < 15; k++) begin
    if (k >= so && k > lastEnd) r.error = 1'b1;  // parcel left without an end
    if (k >= so && (k == so || (k > 0 && ends[k-1])) && k <= lastEnd) begin
      e = k;
      while (!ends[e]) e++;
      if (e - k + 1 > `PREDEC_MAX_LEN) r.error = 1'b1;
      for (int i = 0; i < 4; i++) mg[i] = (k + i > 14) ? 1'b0 : !ends[k + i];
      w = text[k*16 +: 80];
      c = classRef(w[7:0], w[15:13], mg[0], flags[k]);
      if (nI < `PREDEC_SLOTS) begin
        r.instr[nI]   = w;
        r.magic[nI]   = mg;
        r.off[nI]     = 4'(k);
        r.cls[nI]     = c;
        r.instrEn[nI] = 1'b1;
      end
      nI++;
      if (c[`CLS_JUMP]) begin
        if (nJ < `PREDEC_JSLOTS) begin
          r.jInstr[nJ] = w;
          r.jMagic[nJ] = mg;
          r.jOff[nJ]   = 4'(k);
          r.jCls[nJ]   = c;
          r.jEn[nJ]    = 1'b1;
        end
        nJ++;
      end
    end
  end
  if (nI > `PREDEC_SLOTS) r.error = 1'b1;
  r.hasJumps = (nJ > 0);
  r.jerror   = (nJ > `PREDEC_JSLOTS);
  return r;
endfunction

`endif

//--- bench/predecTb.sv
// ==============================
// predecoder testbench
// directed and random bundles against a reference model
// ==============================
`timescale 1ns/1ps
`include "predec_macros.svh"

module predecTb;

  logic                                    clk = 1'b0;
  logic                                    rstN;
  logic                                    bundleValid;
  logic [255:0]                            bundle;
  logic [3:0]                              startOff;
  logic [14:0]                             flagBits;
  logic                                    outValid;
  predecPkg::window_t [`PREDEC_SLOTS-1:0]  instr;
  predecPkg::magic_t [`PREDEC_SLOTS-1:0]   magic;
  logic [`PREDEC_SLOTS-1:0][3:0]           off;
  predecPkg::cls_t [`PREDEC_SLOTS-1:0]     cls;
  logic [`PREDEC_SLOTS-1:0]                instrEn;
  predecPkg::window_t [`PREDEC_JSLOTS-1:0] jInstr;
  predecPkg::magic_t [`PREDEC_JSLOTS-1:0]  jMagic;
  logic [`PREDEC_JSLOTS-1:0][3:0]          jOff;
  predecPkg::cls_t [`PREDEC_JSLOTS-1:0]    jCls;
  logic [`PREDEC_JSLOTS-1:0]               jEn;
  logic                                    hasJumps;
  logic                                    error;
  logic                                    jerror;

  `include "predecModel.svh"

  predResult_t expQ[$];
  int errCount = 0;
  int sentCount = 0;
  int doneCount = 0;
  int testCount = 0;
  int failTests = 0;

  always #50 clk = ~clk;

  predecTop u_predecTop (.*);

  task automatic compareVal(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
      errCount++;
      $display("FAILED at %0d ns: %s got %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic checkResult(input predResult_t x);
    for (int s = 0; s < `PREDEC_SLOTS; s++) begin
      compareVal($sformatf("instr[%0d]", s), instr[s], x.instr[s]);
      compareVal($sformatf("magic[%0d]", s), magic[s], x.magic[s]);
      compareVal($sformatf("off[%0d]", s), off[s], x.off[s]);
      compareVal($sformatf("cls[%0d]", s), cls[s], x.cls[s]);
    end
    for (int s = 0; s < `PREDEC_JSLOTS; s++) begin
      compareVal($sformatf("jInstr[%0d]", s), jInstr[s], x.jInstr[s]);
      compareVal($sformatf("jMagic[%0d]", s), jMagic[s], x.jMagic[s]);
      compareVal($sformatf("jOff[%0d]", s), jOff[s], x.jOff[s]);
      compareVal($sformatf("jCls[%0d]", s), jCls[s], x.jCls[s]);
    end
    compareVal("instrEn", instrEn, x.instrEn);
    compareVal("jEn", jEn, x.jEn);
    compareVal("hasJumps", hasJumps, x.hasJumps);
    compareVal("error", error, x.error);
    compareVal("jerror", jerror, x.jerror);
  endtask

  // outputs are read at the rising edge, before that edge updates them
  initial begin : compareProc
    logic pending;
    predResult_t inFlight;
    pending = 1'b0;
    @(posedge clk);  // first edge clears the registers
    forever begin
      @(posedge clk);
      compareVal("outValid", outValid, pending);
      if (pending) begin
        checkResult(inFlight);
        doneCount++;
      end else begin
        compareVal("instrEn", instrEn, '0);
        compareVal("jEn", jEn, '0);
        compareVal("hasJumps", hasJumps, '0);
        compareVal("error", error, '0);
        compareVal("jerror", jerror, '0);
      end
      pending = bundleValid && rstN;
      if (pending && expQ.size() == 0) begin
        errCount++;
        pending = 1'b0;
        $display("a valid bundle reached the DUT with no expected result queued");
      end else if (pending) begin
        inFlight = expQ.pop_front();
      end
    end
  end

  function automatic logic [239:0] randText();
    logic [255:0] t;
    for (int i = 0; i < 8; i++) t[i*32 +: 32] = $urandom;
    return t[239:0];
  endfunction

  // one parcel per opcode group, sub-field bits stay random
  function automatic logic [239:0] opcodeText();
    logic [7:0] ops [20];
    logic [239:0] t;
    ops = '{8'd0, 8'd4, 8'd27, 8'd31, 8'd40, 8'd45, 8'd46, 8'd51, 8'd64, 8'd95,
            8'd160, 8'd175, 8'd180, 8'd181, 8'd182, 8'd255, 8'd200, 8'h0F, 8'h30, 8'h70};
    t = randText();
    for (int k = 0; k < 15; k++) t[k*16 +: 8] = ops[$urandom_range(19)];
    return t;
  endfunction

  // instructions of minLen..maxLen parcels back to back from so
  function automatic logic [14:0] makeEnds(input int so, input int minLen, input int maxLen);
    logic [14:0] ends;
    int p;
    int e;
    ends = 15'($urandom);  // bits below the offset are noise
    p = so;
    while (p < 15) begin
      e = p + minLen - 1 + $urandom_range(maxLen - minLen);
      if (e > 14) e = 14;
      for (int i = p; i < e; i++) ends[i] = 1'b0;
      ends[e] = 1'b1;
      p = e + 1;
    end
    return ends;
  endfunction

  task automatic sendBundle(input logic [14:0] ends, input logic [239:0] text,
                            input logic [3:0] so, input logic [14:0] flags);
    @(negedge clk);
    bundleValid = 1'b1;
    bundle      = {1'($urandom_range(1)), ends, text};
    startOff    = so;
    flagBits    = flags;
    expQ.push_back(predecodeRef(bundle, so, flags));
    sentCount++;
  endtask

  task automatic idleCycle();
    @(negedge clk);
    bundleValid = 1'b0;
  endtask

  task automatic finishTest(input string name, input int errBefore);
    int waitCycles;
    idleCycle();
    waitCycles = 0;
    while (doneCount != sentCount && waitCycles < 20) begin
      @(negedge clk);
      waitCycles++;
    end
    if (doneCount != sentCount) begin
      errCount++;
      $display("timed out waiting for outValid, %0d of %0d results seen", doneCount, sentCount);
    end
    testCount++;
    if (errCount == errBefore) begin
      $display("test %s: ok", name);
    end else begin
      failTests++;
      $display("test %s: %0d mismatches", name, errCount - errBefore);
    end
  endtask

  initial begin : mainSeq
    int seed;
    int errBefore;
    int rot;
    logic [14:0] ends;
    logic [239:0] text;
    logic [3:0] so;
    logic [7:0] longJumps [4];
    seed = $urandom(83);
    longJumps = '{8'd160, 8'd180, 8'd181, 8'd182};
    rstN        = 1'b0;
    bundleValid = 1'b0;
    bundle      = '0;
    startOff    = '0;
    flagBits    = '0;

    errBefore = errCount;
    repeat (5) @(negedge clk);
    rstN = 1'b1;
    repeat (3) @(negedge clk);
    finishTest("reset state", errBefore);

    errBefore = errCount;
    repeat (30) begin
      so = 4'($urandom_range(14));
      sendBundle(makeEnds(so, 1, 5), randText(), so, 15'($urandom));
      idleCycle();
    end
    finishTest("boundaries and packing", errBefore);

    errBefore = errCount;
    repeat (40) begin
      so = 4'($urandom_range(14));
      sendBundle(makeEnds(so, 1, 5), opcodeText(), so, 15'($urandom));
    end
    // every sub-field under opJumpMisc, seven long starts per bundle
    for (int kind = 0; kind < 8; kind++) begin
      text = randText();
      for (int i = 0; i < 7; i++) begin
        text[i*32 +: 8]      = 8'd182;
        text[i*32 + 13 +: 3] = 3'(kind);
      end
      sendBundle(15'h6AAA, text, 4'd0, 15'($urandom));
    end
    finishTest("classification", errBefore);

    // eight starts at even parcels, the one at parcel 14 is short
    errBefore = errCount;
    for (int nj = 0; nj <= 6; nj++) begin
      repeat (3) begin
        text = randText();
        rot  = $urandom_range(7);
        for (int i = 0; i < 8; i++) begin
          if ((i + rot) % 8 < nj) text[i*32 +: 8] = (i == 7) ? 8'h30 : longJumps[$urandom_range(3)];
          else text[i*32 +: 8] = 8'd1;
        end
        sendBundle(15'h6AAA, text, 4'd0, 15'($urandom));
      end
    end
    finishTest("jump slots", errBefore);

    errBefore = errCount;
    sendBundle(makeEnds(0, 1, 5), randText(), 4'd15, 15'($urandom));
    sendBundle(15'h7FA0, randText(), 4'd0, 15'($urandom));  // six-parcel first instruction
    so = 4'($urandom_range(10));
    sendBundle(makeEnds(so, 1, 5) & 15'h3FFF, randText(), so, 15'($urandom));
    for (int s = 0; s < 3; s++) sendBundle(15'h7FFF, randText(), 4'(s), 15'($urandom));
    finishTest("error cases", errBefore);

    errBefore = errCount;
    repeat (60) begin
      so   = 4'($urandom_range(14));
      ends = ($urandom_range(3) == 0) ? 15'($urandom) : makeEnds(so, 1, 5);
      sendBundle(ends, opcodeText(), so, 15'($urandom));
    end
    finishTest("back-to-back throughput", errBefore);

    $display("%0d tests, %0d failed, %0d mismatches", testCount, failTests, errCount);
    if (errCount == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- hdl/predecTop.sv
// ==============================
// instruction predecoder top
// boundaries, classes and slot packing, one cycle
// ==============================
`timescale 1ns/1ps
`include "predec_macros.svh"

module predecTop (
  input  logic                                   clk,
  input  logic                                   rstN,
  input  logic                                   bundleValid,
  input  logic [255:0]                           bundle,
  input  logic [3:0]                             startOff,
  input  logic [`PREDEC_PARCELS-1:0]             flagBits,
  output logic                                   outValid,
  output predecPkg::window_t [`PREDEC_SLOTS-1:0] instr,
  output predecPkg::magic_t [`PREDEC_SLOTS-1:0]  magic,
  output logic [`PREDEC_SLOTS-1:0][3:0]          off,
  output predecPkg::cls_t [`PREDEC_SLOTS-1:0]    cls,
  output logic [`PREDEC_SLOTS-1:0]               instrEn,
  output predecPkg::window_t [`PREDEC_JSLOTS-1:0] jInstr,
  output predecPkg::magic_t [`PREDEC_JSLOTS-1:0] jMagic,
  output logic [`PREDEC_JSLOTS-1:0][3:0]         jOff,
  output predecPkg::cls_t [`PREDEC_JSLOTS-1:0]   jCls,
  output logic [`PREDEC_JSLOTS-1:0]              jEn,
  output logic                                   hasJumps,
  output logic                                   error,
  output logic                                   jerror
);

  localparam int P      = `PREDEC_PARCELS;
  localparam int TEXT_W = P * `PREDEC_PARCEL_W + `PREDEC_INSTR_W - `PREDEC_PARCEL_W;

  logic [TEXT_W-1:0]                       text;  // zero past the last parcel
  logic [P-1:0]                            startMask;
  logic [P-1:0]                            jumpSel;
  logic                                    lenError;
  predecPkg::magic_t [P-1:0]               parcelMagic;
  predecPkg::window_t [P-1:0]              parcelWin;
  predecPkg::cls_t [P-1:0]                 parcelCls;

  predecPkg::window_t [`PREDEC_SLOTS-1:0]  pickInstr;
  predecPkg::magic_t [`PREDEC_SLOTS-1:0]   pickMagic;
  logic [`PREDEC_SLOTS-1:0][3:0]           pickOff;
  predecPkg::cls_t [`PREDEC_SLOTS-1:0]     pickCls;
  logic [`PREDEC_SLOTS-1:0]                pickEn;
  logic                                    instrOverflow;
  predecPkg::window_t [`PREDEC_JSLOTS-1:0] jPickInstr;
  predecPkg::magic_t [`PREDEC_JSLOTS-1:0]  jPickMagic;
  logic [`PREDEC_JSLOTS-1:0][3:0]          jPickOff;
  predecPkg::cls_t [`PREDEC_JSLOTS-1:0]    jPickCls;
  logic [`PREDEC_JSLOTS-1:0]               jPickEn;
  logic                                    jumpOverflow;

  assign text = TEXT_W'(bundle[P*`PREDEC_PARCEL_W-1:0]);

  predecBoundary u_boundary (
    .endBits   (bundle[P*`PREDEC_PARCEL_W +: P]),
    .startOff  (startOff),
    .startMask (startMask),
    .magic     (parcelMagic),
    .lenError  (lenError)
  );

  for (genvar k = 0; k < P; k++) begin : gClass
    assign parcelWin[k] = text[k*`PREDEC_PARCEL_W +: `PREDEC_INSTR_W];

    predecClassify u_classify (
      .window (parcelWin[k]),
      .magic  (parcelMagic[k]),
      .flag   (flagBits[k]),
      .cls    (parcelCls[k])
    );

    assign jumpSel[k] = startMask[k] & parcelCls[k][`CLS_JUMP];
  end

  predecSlotPick #(.SLOTS(`PREDEC_SLOTS)) u_instrPick (
    .sel       (startMask),
    .window    (parcelWin),
    .magic     (parcelMagic),
    .cls       (parcelCls),
    .slotInstr (pickInstr),
    .slotMagic (pickMagic),
    .slotOff   (pickOff),
    .slotCls   (pickCls),
    .slotEn    (pickEn),
    .overflow  (instrOverflow)
  );

  predecSlotPick #(.SLOTS(`PREDEC_JSLOTS)) u_jumpPick (
    .sel       (jumpSel),
    .window    (parcelWin),
    .magic     (parcelMagic),
    .cls       (parcelCls),
    .slotInstr (jPickInstr),
    .slotMagic (jPickMagic),
    .slotOff   (jPickOff),
    .slotCls   (jPickCls),
    .slotEn    (jPickEn),
    .overflow  (jumpOverflow)
  );

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      outValid <= 1'b0;
      instrEn  <= '0;
      jEn      <= '0;
      hasJumps <= 1'b0;
      error    <= 1'b0;
      jerror   <= 1'b0;
    end else begin
      outValid <= bundleValid;
      instrEn  <= bundleValid ? pickEn : '0;
      jEn      <= bundleValid ? jPickEn : '0;
      hasJumps <= bundleValid && (|jumpSel);
      error    <= bundleValid && (lenError || instrOverflow);
      jerror   <= bundleValid && jumpOverflow;  // fifth jump and beyond are lost
    end
  end

  // slot payload only moves with a valid bundle
  always_ff @(posedge clk) begin
    if (bundleValid) begin
      instr  <= pickInstr;
      magic  <= pickMagic;
      off    <= pickOff;
      cls    <= pickCls;
      jInstr <= jPickInstr;
      jMagic <= jPickMagic;
      jOff   <= jPickOff;
      jCls   <= jPickCls;
    end
  end

  validLowAfterReset: assert property (@(posedge clk) $rose(rstN) |-> !outValid)
    else $error("outValid high on the first edge after reset release");

endmodule

//--- hdl/predecSlotPick.sv
// ==============================
// ordered slot packer
// routes the n-th selected parcel to slot n
// ==============================
`timescale 1ns/1ps
`include "predec_macros.svh"

module predecSlotPick #(
  parameter int SLOTS = 12
) (
  input  logic [`PREDEC_PARCELS-1:0]               sel,
  input  predecPkg::window_t [`PREDEC_PARCELS-1:0] window,
  input  predecPkg::magic_t [`PREDEC_PARCELS-1:0]  magic,
  input  predecPkg::cls_t [`PREDEC_PARCELS-1:0]    cls,
  output predecPkg::window_t [SLOTS-1:0]           slotInstr,
  output predecPkg::magic_t [SLOTS-1:0]            slotMagic,
  output logic [SLOTS-1:0][3:0]                    slotOff,
  output predecPkg::cls_t [SLOTS-1:0]              slotCls,
  output logic [SLOTS-1:0]                         slotEn,
  output logic                                     overflow
);

  localparam int P = `PREDEC_PARCELS;

  logic [P-1:0][3:0] rank;  // selected parcels below k
  logic [3:0]        total;
  logic [SLOTS-1:0]  enPlusOne;

  always_comb begin
    total = '0;
    for (int k = 0; k < P; k++) begin
      rank[k] = total;
      total   = total + 4'(sel[k]);
    end
  end

  // and-or mux, at most one parcel matches each slot
  always_comb begin
    slotInstr = '0;
    slotMagic = '0;
    slotOff   = '0;
    slotCls   = '0;
    for (int s = 0; s < SLOTS; s++) begin
      for (int k = 0; k < P; k++) begin
        if (sel[k] && rank[k] == 4'(s)) begin
          slotInstr[s] = window[k];
          slotMagic[s] = magic[k];
          slotOff[s]   = 4'(k);
          slotCls[s]   = cls[k];
        end
      end
    end
  end

  for (genvar s = 0; s < SLOTS; s++) begin : gEn
    assign slotEn[s] = (total > 4'(s));
  end

  assign overflow  = (total > 4'(SLOTS));
  assign enPlusOne = slotEn + 1'b1;

  // enables fill up from slot 0, one per selected parcel up to SLOTS
  slotEnThermo: assert final ($isunknown(sel)
                              || ((slotEn & enPlusOne) == '0
                                  && $countones(slotEn) == (($countones(sel) > SLOTS)
                                                            ? SLOTS : $countones(sel))))
    else $error("slot enables %b wrong for %0d selected parcels", slotEn,
                $countones(sel));

endmodule

//--- hdl/predecClassify.sv
// ==============================
// instruction classifier
// maps one instruction window to its class vector
// ==============================
`timescale 1ns/1ps
`include "predec_macros.svh"

module predecClassify (
  input  predecPkg::window_t window,
  input  predecPkg::magic_t  magic,
  input  logic               flag,
  output predecPkg::cls_t    cls
);

  logic [7:0]           opcode;
  logic                 isLong;
  predecPkg::opcode_e   opMain;
  predecPkg::jumpKind_e jumpKind;

  assign opcode   = window[7:0];
  assign isLong   = magic[0];
  assign opMain   = predecPkg::opcode_e'(opcode);
  assign jumpKind = predecPkg::jumpKind_e'(window[15:13]);

  always_comb begin
    cls = '0;
    if (isLong) begin
      if (opcode[7:5] == 3'b000) begin
        cls[`CLS_ALU] = ~opcode[2];
        cls[`CLS_MUL] = opcode[2];
      end
      if (opcode >= 8'd40 && opcode <= 8'd45) cls[`CLS_SHIFT] = 1'b1;
      if (opcode >= 8'd46 && opcode <= 8'd51) cls[`CLS_ALU] = 1'b1;
      if (opcode[7:5] == 3'b010) begin  // 64..95, odd opcodes store
        cls[`CLS_LOAD]  = ~opcode[0];
        cls[`CLS_STORE] = opcode[0];
      end
      if (opcode[7:4] == 4'hA) begin  // compare and branch
        cls[`CLS_JUMP] = 1'b1;
        cls[`CLS_ALU]  = 1'b1;
      end
      if (opMain == predecPkg::opCondJumpLong || opMain == predecPkg::opJump) begin
        cls[`CLS_JUMP] = 1'b1;
      end
      if (opMain == predecPkg::opJumpMisc) begin
        cls[`CLS_JUMP] = 1'b1;
        case (jumpKind)
          predecPkg::jkIndir,
          predecPkg::jkRet:     cls[`CLS_INDIR] = 1'b1;
          predecPkg::jkCall,
          predecPkg::jkCallFar: cls[`CLS_STORE] = 1'b1;  // return address push
          default:              cls[`CLS_INDIR] = 1'b0;
        endcase
      end
      if (opMain == predecPkg::opSys) cls[`CLS_SYS] = 1'b1;
    end else begin
      // short form decodes on the low six bits only
      if (opcode[5:4] == 2'b00) cls[`CLS_ALU] = 1'b1;
      if (opcode[5:2] == 4'b1100) cls[`CLS_JUMP] = 1'b1;
    end
    cls[`CLS_FLAG] = flag;
  end

endmodule

//--- hdl/predecBoundary.sv
// ==============================
// instruction boundary finder
// start mask, magic length codes and length errors
// ==============================
`timescale 1ns/1ps
`include "predec_macros.svh"

module predecBoundary (
  input  logic [`PREDEC_PARCELS-1:0]              endBits,
  input  logic [3:0]                              startOff,
  output logic [`PREDEC_PARCELS-1:0]              startMask,
  output predecPkg::magic_t [`PREDEC_PARCELS-1:0] magic,
  output logic                                    lenError
);

  localparam int P  = `PREDEC_PARCELS;
  localparam int MW = $bits(predecPkg::magic_t);

  logic [P+MW-1:0]                endHigh;  // past parcel 14 reads as ended
  logic [P+`PREDEC_MAX_LEN-2:0]   endLow;   // past parcel 14 reads as open
  logic [P-1:0]                   prevEnd;
  logic [P-1:0]                   tooLong;
  logic [P:0]                     belowOff;
  logic                           badOff;
  logic                           openTail;

  assign endHigh = {{MW{1'b1}}, endBits};
  assign endLow  = {{(`PREDEC_MAX_LEN-1){1'b0}}, endBits};
  assign prevEnd = {endBits[P-2:0], 1'b0};

  for (genvar k = 0; k < P; k++) begin : gParcel
    // first parcel at the offset, or right after an end, and terminated somewhere
    assign startMask[k] = (startOff <= 4'(k)) && (startOff == 4'(k) || prevEnd[k])
                          && |endBits[P-1:k];
    assign magic[k]     = ~endHigh[k +: MW];
    assign tooLong[k]   = startMask[k] && (endLow[k +: `PREDEC_MAX_LEN] == '0);
  end

  assign badOff   = (startOff == 4'(P));
  assign openTail = !badOff && !endBits[P-1];  // last parcel not closed
  assign lenError = badOff || openTail || (|tooLong);

  assign belowOff = ((P+1)'(1) << startOff) - (P+1)'(1);

  // starts begin on the fetch offset and never below it
  startAboveOff: assert final ($isunknown({startOff, endBits})
                               || ((startMask & belowOff[P-1:0]) == '0
                                   && (startMask == '0 || startMask[startOff])))
    else $error("start mask %b does not begin at startOff %0d", startMask, startOff);

endmodule

//--- common/predecPkg.sv
// ==============================
// predecoder types
// opcodes, jump kinds, class vector and slot payloads
// ==============================
`include "predec_macros.svh"

package predecPkg;

  // main opcodes that get an exact match in classify
  typedef enum logic [7:0] {
    opCondJumpLong = 8'd180,
    opJump         = 8'd181,
    opJumpMisc     = 8'd182,
    opSys          = 8'd255
  } opcode_e;

  // instr[15:13] under opJumpMisc
  typedef enum logic [2:0] {
    jkIndir   = 3'd0,
    jkCall    = 3'd1,
    jkCallFar = 3'd2,
    jkRet     = 3'd3
  } jumpKind_e;

  typedef logic [`PREDEC_CLS_W-1:0] cls_t;

  // inverted end bits of parcels k..k+3, bit 0 set means multi-parcel
  typedef logic [3:0] magic_t;

  typedef logic [`PREDEC_INSTR_W-1:0] window_t;

endpackage

//--- common/predec_macros.svh
// ==============================
// predecoder sizing macros
// parcel, window and slot counts, class bit positions
// ==============================
`ifndef PREDEC_MACROS_SVH
`define PREDEC_MACROS_SVH

`define PREDEC_PARCELS  15
`define PREDEC_PARCEL_W 16
`define PREDEC_INSTR_W  80  // five parcels
`define PREDEC_MAX_LEN  5
`define PREDEC_SLOTS    12
`define PREDEC_JSLOTS   4
`define PREDEC_CLS_W    9

// class vector bits
`define CLS_ALU   0
`define CLS_SHIFT 1
`define CLS_MUL   2
`define CLS_LOAD  3
`define CLS_STORE 4
`define CLS_JUMP  5
`define CLS_INDIR 6
`define CLS_SYS   7
`define CLS_FLAG  8

`endif
